// ==== rtl/axil_fabric_macros.svh ====
// Region 0 is the SRAM and region 1 the monitor, any other region answers with an error
// Region sits in address bits 31:12, word index in 11:2

`ifndef AXIL_FABRIC_MACROS_SVH
`define AXIL_FABRIC_MACROS_SVH

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Address field split
`define AXIL_REGION_W 20
`define AXIL_WIDX_W 10
`define AXIL_BOFF_W 2

// Memory depth in words
`define AXIL_SRAM_WORDS 256

// Region numbers
`define AXIL_REGION_SRAM 0
`define AXIL_REGION_PMON 1

`endif

// ==== rtl/axil_fabric_pkg.sv ====
// Request and response types shared by every block of the fabric
// Field widths follow the macros header

`default_nettype none

`include "axil_fabric_macros.svh"

package axil_fabric_pkg;

  // Decoded view of a byte address
  typedef struct packed {
    logic [`AXIL_REGION_W-1:0] region;
    logic [`AXIL_WIDX_W-1:0]   widx;
    logic [`AXIL_BOFF_W-1:0]   boff;
  } axil_addr_fields_t;

  // One address word, seen raw or split into fields
  typedef union packed {
    logic [`AXIL_ADDR_W-1:0] raw;
    axil_addr_fields_t       f;
  } axil_addr_u;

  // Request channel payload, 69 bits
  typedef struct packed {
    logic                    write;
    axil_addr_u              addr;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] strb;
  } axil_req_t;

  // Response channel payload, 33 bits
  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] rdata;
    logic                    err;
  } axil_resp_t;

  // Source of the pending response
  typedef enum logic [1:0] {
    slv_sram = 2'd0,
    slv_pmon = 2'd1,
    slv_err  = 2'd2
  } axil_slave_e;

endpackage

`default_nettype wire

// ==== rtl/axil_arbiter.sv ====
// Round-robin arbiter for two masters, one transaction in flight at a time
// Response data is shared; only the owner's response valid is raised

`timescale 1ns/1ps
`default_nettype none

module axil_arbiter
  import axil_fabric_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  // Master request side
  input  wire logic       m_req_valid_i [2],
  input  wire axil_req_t  m_req_i [2],
  output logic            m_req_ready_o [2],
  // Master response side
  output logic            m_resp_valid_o [2],
  output axil_resp_t      m_resp_o,
  input  wire logic       m_resp_ready_i [2],
  // Toward the decoder
  output logic            bus_req_valid_o,
  output axil_req_t       bus_req_o,
  output logic            bus_gnt_o,
  input  wire logic       bus_resp_valid_i,
  input  wire axil_resp_t bus_resp_i
);

  logic       busy_q;
  logic       owner_q;
  logic       prio_q;
  logic       req_valid_q;
  axil_req_t  req_q;
  logic       hold_valid_q;
  axil_resp_t hold_q;

  logic       gnt_valid;
  logic       gnt_idx;
  logic       req_hs;
  logic       cur_valid;
  logic       accept;

  // Favored master wins, otherwise the other one if it asks
  always_comb begin
    gnt_valid = m_req_valid_i[0] || m_req_valid_i[1];
    if (m_req_valid_i[prio_q]) begin
      gnt_idx = prio_q;
    end else begin
      gnt_idx = ~prio_q;
    end
  end

  assign req_hs = !busy_q && gnt_valid;

  // Response is shown the cycle it arrives, then held until taken
  assign cur_valid = hold_valid_q || bus_resp_valid_i;
  assign m_resp_o  = hold_valid_q ? hold_q : bus_resp_i;
  assign accept    = cur_valid && m_resp_ready_i[owner_q];

  for (genvar i = 0; i < 2; i++) begin : g_port
    assign m_req_ready_o[i]  = req_hs && (gnt_idx == 1'(i));
    assign m_resp_valid_o[i] = cur_valid && (owner_q == 1'(i));
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q       <= 1'b0;
      owner_q      <= 1'b0;
      prio_q       <= 1'b0;
      req_valid_q  <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_hs;
      if (req_hs) begin
        busy_q  <= 1'b1;
        owner_q <= gnt_idx;
        // Last served master loses the next tie
        prio_q  <= ~gnt_idx;
      end else if (accept) begin
        busy_q <= 1'b0;
      end
      if (accept) begin
        hold_valid_q <= 1'b0;
      end else if (bus_resp_valid_i) begin
        hold_valid_q <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= m_req_i[gnt_idx];
    end
    if (bus_resp_valid_i) begin
      hold_q <= bus_resp_i;
    end
  end

  assign bus_req_valid_o = req_valid_q;
  assign bus_req_o       = req_q;
  assign bus_gnt_o       = owner_q;

endmodule

`default_nettype wire

// ==== rtl/axil_demux.sv ====
// Address decoder; regions other than SRAM and monitor answer with an error
// Slaves must respond exactly one cycle after their request strobe

`timescale 1ns/1ps
`default_nettype none

`include "axil_fabric_macros.svh"

module axil_demux
  import axil_fabric_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       bus_req_valid_i,
  input  wire axil_req_t  bus_req_i,
  output logic            bus_resp_valid_o,
  output axil_resp_t      bus_resp_o,
  output logic            sram_req_valid_o,
  output logic            pmon_req_valid_o,
  output axil_req_t       slv_req_o,
  input  wire logic       sram_resp_valid_i,
  input  wire axil_resp_t sram_resp_i,
  input  wire logic       pmon_resp_valid_i,
  input  wire axil_resp_t pmon_resp_i
);

  axil_req_t   req_q;
  axil_slave_e src_q;
  axil_slave_e dec_src;
  logic        fwd_q;
  logic        err_valid_q;

  // Region decode through the split address view
  always_comb begin
    if (bus_req_i.addr.f.region == `AXIL_REGION_W'(`AXIL_REGION_SRAM)) begin
      dec_src = slv_sram;
    end else if (bus_req_i.addr.f.region == `AXIL_REGION_W'(`AXIL_REGION_PMON)) begin
      dec_src = slv_pmon;
    end else begin
      dec_src = slv_err;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fwd_q       <= 1'b0;
      err_valid_q <= 1'b0;
      src_q       <= slv_sram;
    end else begin
      fwd_q <= bus_req_valid_i;
      if (bus_req_valid_i) begin
        src_q <= dec_src;
      end
      // Error answer matches the one-cycle slave latency
      err_valid_q <= fwd_q && (src_q == slv_err);
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_req_valid_i) begin
      req_q <= bus_req_i;
    end
  end

  assign slv_req_o        = req_q;
  assign sram_req_valid_o = fwd_q && (src_q == slv_sram);
  assign pmon_req_valid_o = fwd_q && (src_q == slv_pmon);

  // Return path selected by the pending source
  always_comb begin
    case (src_q)
      slv_sram: begin
        bus_resp_valid_o = sram_resp_valid_i;
        bus_resp_o       = sram_resp_i;
      end
      slv_pmon: begin
        bus_resp_valid_o = pmon_resp_valid_i;
        bus_resp_o       = pmon_resp_i;
      end
      default: begin
        bus_resp_valid_o = err_valid_q;
        bus_resp_o       = '{rdata: '0, err: 1'b1};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/axil_sram_slave.sv ====
// Single-port word memory with byte-lane writes and one-cycle response
// Word index bits above the memory depth are ignored, so the SRAM aliases

`timescale 1ns/1ps
`default_nettype none

`include "axil_fabric_macros.svh"

module axil_sram_slave
  import axil_fabric_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire logic      req_valid_i,
  input  wire axil_req_t req_i,
  output logic           resp_valid_o,
  output axil_resp_t     resp_o
);

  localparam int IdxW = $clog2(`AXIL_SRAM_WORDS);

  logic [`AXIL_DATA_W-1:0] mem [`AXIL_SRAM_WORDS];
  logic [IdxW-1:0]         idx;
  logic                    resp_valid_q;
  logic [`AXIL_DATA_W-1:0] rdata_q;

  assign idx = req_i.addr.f.widx[IdxW-1:0];

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        for (int b = 0; b < `AXIL_STRB_W; b++) begin
          if (req_i.strb[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        // Writes answer with zero data
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== rtl/axil_perf_mon.sv ====
// Counts request handshakes per master and delivered error responses
// Word 0 and 1 are master counts, word 2 errors; any write clears all three

`timescale 1ns/1ps
`default_nettype none

`include "axil_fabric_macros.svh"

module axil_perf_mon
  import axil_fabric_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  // Observed events
  input  wire logic      acc_valid_i [2],
  input  wire logic      resp_err_i,
  // Register access
  input  wire logic      req_valid_i,
  input  wire axil_req_t req_i,
  output logic           resp_valid_o,
  output axil_resp_t     resp_o
);

  logic [`AXIL_DATA_W-1:0] cnt_q [3];
  logic [`AXIL_DATA_W-1:0] rd_mux;
  logic [`AXIL_DATA_W-1:0] rdata_q;
  logic                    resp_valid_q;
  logic                    clear;

  assign clear = req_valid_i && req_i.write;

  // Only one transaction is in flight, so a clear never meets an event
  always_ff @(posedge clk_i) begin
    if (reset_i || clear) begin
      for (int k = 0; k < 3; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      if (acc_valid_i[0]) begin
        cnt_q[0] <= cnt_q[0] + 1'b1;
      end
      if (acc_valid_i[1]) begin
        cnt_q[1] <= cnt_q[1] + 1'b1;
      end
      if (resp_err_i) begin
        cnt_q[2] <= cnt_q[2] + 1'b1;
      end
    end
  end

  // Counter select by word index, unused words read zero
  always_comb begin
    case (req_i.addr.f.widx)
      `AXIL_WIDX_W'(0): rd_mux = cnt_q[0];
      `AXIL_WIDX_W'(1): rd_mux = cnt_q[1];
      `AXIL_WIDX_W'(2): rd_mux = cnt_q[2];
      default:          rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= req_i.write ? '0 : rd_mux;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== rtl/axil_fabric_top.sv ====
// Two-master fabric: arbiter, address decoder, SRAM and performance monitor
// Request handshake to response valid is three cycles for every target

`timescale 1ns/1ps
`default_nettype none

module axil_fabric_top
  import axil_fabric_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       reset_i,
  input  wire logic       m_req_valid_i [2],
  input  wire axil_req_t  m_req_i [2],
  output logic            m_req_ready_o [2],
  output logic            m_resp_valid_o [2],
  output axil_resp_t      m_resp_o,
  input  wire logic       m_resp_ready_i [2]
);

  logic       bus_req_valid;
  axil_req_t  bus_req;
  logic       bus_gnt;
  logic       bus_resp_valid;
  axil_resp_t bus_resp;
  logic       sram_req_valid;
  logic       pmon_req_valid;
  axil_req_t  slv_req;
  logic       sram_resp_valid;
  axil_resp_t sram_resp;
  logic       pmon_resp_valid;
  axil_resp_t pmon_resp;
  logic       acc_valid [2];
  logic       resp_err;

  // Monitor events taken from the master ports
  for (genvar i = 0; i < 2; i++) begin : g_acc
    assign acc_valid[i] = m_req_valid_i[i] && m_req_ready_o[i];
  end
  assign resp_err = m_resp_valid_o[bus_gnt] && m_resp_ready_i[bus_gnt] && m_resp_o.err;

  axil_arbiter u_arbiter (
    .clk_i, .reset_i,
    .m_req_valid_i, .m_req_i, .m_req_ready_o,
    .m_resp_valid_o, .m_resp_o, .m_resp_ready_i,
    .bus_req_valid_o  (bus_req_valid),
    .bus_req_o        (bus_req),
    .bus_gnt_o        (bus_gnt),
    .bus_resp_valid_i (bus_resp_valid),
    .bus_resp_i       (bus_resp)
  );

  axil_demux u_demux (
    .clk_i, .reset_i,
    .bus_req_valid_i   (bus_req_valid),
    .bus_req_i         (bus_req),
    .bus_resp_valid_o  (bus_resp_valid),
    .bus_resp_o        (bus_resp),
    .sram_req_valid_o  (sram_req_valid),
    .pmon_req_valid_o  (pmon_req_valid),
    .slv_req_o         (slv_req),
    .sram_resp_valid_i (sram_resp_valid),
    .sram_resp_i       (sram_resp),
    .pmon_resp_valid_i (pmon_resp_valid),
    .pmon_resp_i       (pmon_resp)
  );

  axil_sram_slave u_sram (
    .clk_i, .reset_i,
    .req_valid_i  (sram_req_valid),
    .req_i        (slv_req),
    .resp_valid_o (sram_resp_valid),
    .resp_o       (sram_resp)
  );

  axil_perf_mon u_pmon (
    .clk_i, .reset_i,
    .acc_valid_i  (acc_valid),
    .resp_err_i   (resp_err),
    .req_valid_i  (pmon_req_valid),
    .req_i        (slv_req),
    .resp_valid_o (pmon_resp_valid),
    .resp_o       (pmon_resp)
  );

endmodule

`default_nettype wire

// ==== verification/axil_fabric_properties.sv ====
// Protocol checks on the fabric master ports, bound into the top level
// Latency checks assume a single transaction in flight

`timescale 1ns/1ps
`default_nettype none

`include "axil_fabric_macros.svh"

module axil_fabric_properties
  import axil_fabric_pkg::*;
(
  input wire logic       clk_i,
  input wire logic       reset_i,
  input wire logic       m_req_valid_i [2],
  input wire axil_req_t  m_req_i [2],
  input wire logic       m_req_ready_i [2],
  input wire logic       m_resp_valid_i [2],
  input wire axil_resp_t m_resp_i,
  input wire logic       m_resp_ready_i [2]
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Only one master wins the request path
  a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    !(m_req_ready_i[0] && m_req_ready_i[1]))
    else begin
      fail_cnt++;
      $error("both request readies are high");
    end

  for (genvar i = 0; i < 2; i++) begin : g_port
    logic hs;
    logic unmapped;

    assign hs       = m_req_valid_i[i] && m_req_ready_i[i];
    assign unmapped = m_req_i[i].addr.f.region > `AXIL_REGION_W'(`AXIL_REGION_PMON);

    a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      m_resp_valid_i[i] && !m_resp_ready_i[i] |=> m_resp_valid_i[i] && $stable(m_resp_i))
      else begin
        fail_cnt++;
        $error("response on master %0d changed before it was accepted", i);
      end

    // A waiting response holds off both masters
    a_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
      m_resp_valid_i[i] && !m_resp_ready_i[i] |-> !m_req_ready_i[0] && !m_req_ready_i[1])
      else begin
        fail_cnt++;
        $error("request accepted while master %0d response is pending", i);
      end

    // Response valid first shows in the third cycle after the handshake
    a_latency: assert property (@(posedge clk_i) disable iff (reset_i)
      hs |=> !m_resp_valid_i[i] ##1 !m_resp_valid_i[i] ##1 m_resp_valid_i[i])
      else begin
        fail_cnt++;
        $error("master %0d response not valid exactly 3 cycles after the request", i);
      end

    a_unmapped_err: assert property (@(posedge clk_i) disable iff (reset_i)
      hs && unmapped |-> ##3 m_resp_i.err && (m_resp_i.rdata == '0))
      else begin
        fail_cnt++;
        $error("unmapped access by master %0d did not return an error", i);
      end
  end

endmodule

`default_nettype wire

// ==== verification/axil_fabric_tb.sv ====
// Models SRAM words and monitor counters; the bound properties check the protocol
// Inputs change on the falling edge and outputs are sampled 1 ns later

`timescale 1ns/1ps
`default_nettype none

`include "axil_fabric_macros.svh"

module axil_fabric_tb
  import axil_fabric_pkg::*;
();

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 10;
  localparam int TxnCycles   = 20;
  // Transactions per test, in test order
  localparam int TotalTxns   = 48 + 32 + 8 + 14 + 16 + 4;

  logic       clk;
  logic       rst;
  logic       req_valid [2];
  axil_req_t  req [2];
  logic       req_ready [2];
  logic       resp_valid [2];
  axil_resp_t resp;
  logic       resp_ready [2];

  integer      seed;
  int          checks;
  int          errors;
  int          last_errors;
  int          tests;
  string       cur_test;
  logic [31:0] mem_m [`AXIL_SRAM_WORDS];
  // Words 0 and 1 count master requests, word 2 delivered errors
  logic [31:0] cnt_m [3];
  bit          grant_log [$];

  axil_fabric_top dut (
    .clk_i          (clk),
    .reset_i        (rst),
    .m_req_valid_i  (req_valid),
    .m_req_i        (req),
    .m_req_ready_o  (req_ready),
    .m_resp_valid_o (resp_valid),
    .m_resp_o       (resp),
    .m_resp_ready_i (resp_ready)
  );

  bind axil_fabric_top axil_fabric_properties u_props (
    .clk_i,
    .reset_i,
    .m_req_valid_i,
    .m_req_i,
    .m_req_ready_i  (m_req_ready_o),
    .m_resp_valid_i (m_resp_valid_o),
    .m_resp_i       (m_resp_o),
    .m_resp_ready_i
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #((TotalTxns * TxnCycles + 4 * ResetCycles) * ClkPeriod);
    $display("Watchdog expired: the tests did not finish within their transaction budget");
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_stall(input int max);
    logic [31:0] w;
    w = $random(seed);
    return int'(w % 32'(max));
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return r;
  endfunction

  function automatic axil_req_t make_req(input logic wr, input logic [19:0] region,
                                         input logic [9:0] widx, input logic [31:0] wdata,
                                         input logic [3:0] strb);
    axil_req_t r;
    r.write         = wr;
    r.addr.f.region = region;
    r.addr.f.widx   = widx;
    r.addr.f.boff   = 2'b00;
    r.wdata         = wdata;
    r.strb          = strb;
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] expv, input logic [31:0] act);
    checks++;
    if (act !== expv) begin
      errors++;
      $display("[ERROR] %0s %0s: expected %h, actual %h", cur_test, name, expv, act);
    end
  endtask

  // One full transaction on master m, entered and left on a falling edge
  // Stall is the number of cycles the response waits
  task automatic do_txn(input bit m, input axil_req_t r, input int stall,
                        output axil_resp_t rsp);
    req_valid[m] = 1'b1;
    req[m]       = r;
    #1;
    while (!req_ready[m]) begin
      @(negedge clk);
      #1;
    end
    // Handshake on the coming rising edge
    grant_log.push_back(m);
    cnt_m[m] = cnt_m[m] + 1;
    @(negedge clk);
    req_valid[m]  = 1'b0;
    resp_ready[m] = (stall == 0);
    #1;
    while (!resp_valid[m]) begin
      @(negedge clk);
      #1;
    end
    if (stall > 0) begin
      repeat (stall) @(negedge clk);
      resp_ready[m] = 1'b1;
      #1;
    end
    rsp = resp;
    @(negedge clk);
    resp_ready[m] = 1'b0;
  endtask

  task automatic sram_write(input bit m, input logic [7:0] idx, input logic [31:0] data,
                            input logic [3:0] strb, input int stall);
    axil_resp_t rsp;
    do_txn(m, make_req(1'b1, 20'(`AXIL_REGION_SRAM), {2'b00, idx}, data, strb), stall, rsp);
    mem_m[idx] = merge_bytes(mem_m[idx], data, strb);
    check_val($sformatf("write word %0d error flag", idx), 32'd0, {31'd0, rsp.err});
  endtask

  task automatic sram_read(input bit m, input logic [7:0] idx, input int stall);
    axil_resp_t rsp;
    do_txn(m, make_req(1'b0, 20'(`AXIL_REGION_SRAM), {2'b00, idx}, 32'd0, 4'h0), stall, rsp);
    check_val($sformatf("read word %0d by master %0d", idx, m), mem_m[idx], rsp.rdata);
    check_val($sformatf("read word %0d error flag", idx), 32'd0, {31'd0, rsp.err});
  endtask

  task automatic pmon_read(input bit m, input logic [1:0] k);
    axil_resp_t rsp;
    do_txn(m, make_req(1'b0, 20'(`AXIL_REGION_PMON), {8'd0, k}, 32'd0, 4'h0), 0, rsp);
    check_val($sformatf("counter %0d read by master %0d", k, m), cnt_m[k], rsp.rdata);
  endtask

  task automatic pmon_clear(input bit m);
    axil_resp_t rsp;
    do_txn(m, make_req(1'b1, 20'(`AXIL_REGION_PMON), 10'd0, rand_word(), 4'hf), 0, rsp);
    for (int k = 0; k < 3; k++) begin
      cnt_m[k] = 32'd0;
    end
    check_val("counter clear error flag", 32'd0, {31'd0, rsp.err});
  endtask

  task automatic err_access(input bit m, input logic [19:0] region, input logic wr,
                            input logic [7:0] idx);
    axil_resp_t rsp;
    do_txn(m, make_req(wr, region, {2'b00, idx}, rand_word(), 4'hf), 0, rsp);
    cnt_m[2] = cnt_m[2] + 1;
    check_val($sformatf("region %h error flag", region), 32'd1, {31'd0, rsp.err});
    check_val($sformatf("region %h read data", region), 32'd0, rsp.rdata);
  endtask

  task automatic check_idle();
    check_val("req_ready[0] after reset", 32'd0, 32'(req_ready[0]));
    check_val("req_ready[1] after reset", 32'd0, 32'(req_ready[1]));
    check_val("resp_valid[0] after reset", 32'd0, 32'(resp_valid[0]));
    check_val("resp_valid[1] after reset", 32'd0, 32'(resp_valid[1]));
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic end_test();
    tests++;
    $display("Test %0s done: %0d errors", cur_test, errors - last_errors);
    last_errors = errors;
  endtask

  initial begin
    logic [31:0] rnd;
    seed        = 18483;
    checks      = 0;
    errors      = 0;
    last_errors = 0;
    tests       = 0;
    rst         = 1'b1;
    for (int i = 0; i < 2; i++) begin
      req_valid[i]  = 1'b0;
      req[i]        = '0;
      resp_ready[i] = 1'b0;
    end
    for (int k = 0; k < 3; k++) begin
      cnt_m[k] = 32'd0;
    end
    apply_reset();

    // Full words first so every later strobe merge starts from known bytes
    cur_test = "sram_strobes";
    for (int i = 0; i < 16; i++) begin
      sram_write(1'(i), 8'(i), rand_word(), 4'hf, 0);
    end
    for (int i = 0; i < 16; i++) begin
      rnd = rand_word();
      sram_write(rnd[31], {4'd0, rnd[3:0]}, rand_word(), rnd[7:4], 0);
    end
    for (int i = 0; i < 16; i++) begin
      sram_read(1'(i + 1), 8'(i), 0);
    end
    end_test();

    // Each master asks again in the cycle its response is taken, so every grant is a tie
    cur_test = "round_robin";
    grant_log.delete();
    fork
      begin
        for (int j = 0; j < 8; j++) begin
          sram_write(1'b0, 8'(32 + j), rand_word(), 4'hf, 0);
        end
      end
      begin
        for (int j = 0; j < 8; j++) begin
          sram_write(1'b1, 8'(40 + j), rand_word(), 4'hf, 0);
        end
      end
    join
    check_val("grant count", 32'd16, 32'(grant_log.size()));
    for (int i = 1; i < grant_log.size(); i++) begin
      checks++;
      if (grant_log[i] == grant_log[i - 1]) begin
        errors++;
        $display("round_robin: master %0d was granted twice in a row at grant %0d",
                 grant_log[i], i);
      end
    end
    for (int i = 0; i < 16; i++) begin
      sram_read(1'(i), 8'(32 + i), 0);
    end
    end_test();

    cur_test = "unmapped";
    err_access(1'b0, 20'h00002, 1'b1, 8'd0);
    err_access(1'b1, 20'h00003, 1'b0, 8'd1);
    err_access(1'b0, 20'hfffff, 1'b1, 8'd2);
    rnd = rand_word();
    err_access(1'b1, rnd[19:0] | 20'h00002, 1'b1, 8'd3);
    for (int i = 0; i < 4; i++) begin
      sram_read(1'(i), 8'(i), 0);
    end
    end_test();

    cur_test = "perf_mon";
    pmon_clear(1'b1);
    pmon_read(1'b0, 2'd0);
    pmon_read(1'b1, 2'd1);
    pmon_read(1'b0, 2'd2);
    err_access(1'b1, 20'h00010, 1'b0, 8'd5);
    err_access(1'b0, 20'h00020, 1'b1, 8'd6);
    sram_read(1'b1, 8'd7, 0);
    pmon_read(1'b0, 2'd0);
    pmon_read(1'b1, 2'd1);
    pmon_read(1'b1, 2'd2);
    pmon_clear(1'b0);
    pmon_read(1'b1, 2'd0);
    pmon_read(1'b0, 2'd0);
    pmon_read(1'b1, 2'd2);
    end_test();

    // Master 0 stalls its responses while master 1 keeps asking
    cur_test = "backpressure";
    fork
      begin
        for (int j = 0; j < 4; j++) begin
          sram_write(1'b0, 8'(64 + j), rand_word(), 4'hf, 1 + rand_stall(8));
          sram_read(1'b0, 8'(64 + j), 1 + rand_stall(8));
        end
      end
      begin
        for (int j = 0; j < 4; j++) begin
          sram_write(1'b1, 8'(80 + j), rand_word(), 4'hf, rand_stall(4));
          sram_read(1'b1, 8'(80 + j), rand_stall(4));
        end
      end
    join
    end_test();

    // Reset arrives while a read response waits on master 0
    cur_test = "reset";
    req_valid[0] = 1'b1;
    req[0]       = make_req(1'b0, 20'(`AXIL_REGION_SRAM), 10'd1, 32'd0, 4'h0);
    #1;
    while (!req_ready[0]) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req_valid[0] = 1'b0;
    repeat (2) @(negedge clk);
    apply_reset();
    #1;
    check_idle();
    for (int k = 0; k < 3; k++) begin
      cnt_m[k] = 32'd0;
    end
    @(negedge clk);
    pmon_read(1'b0, 2'd0);
    pmon_read(1'b0, 2'd1);
    pmon_read(1'b0, 2'd2);
    end_test();

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, dut.u_props.fail_cnt);
    if (errors == 0 && dut.u_props.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== axil_fabric.f ====
+incdir+rtl
rtl/axil_fabric_pkg.sv
rtl/axil_arbiter.sv
rtl/axil_demux.sv
rtl/axil_sram_slave.sv
rtl/axil_perf_mon.sv
rtl/axil_fabric_top.sv
verification/axil_fabric_properties.sv
verification/axil_fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fabric testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module axil_fabric_tb -f axil_fabric.f -o sim_axil_fabric

./obj_dir/sim_axil_fabric | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run_sim: testbench reported failure"
  exit 1
fi
echo "run_sim: testbench reported no failure"
